/* src/div_consts.svh */
// *********************************************************************
// Divide unit constants.
// Operand width, result tag width and default FIFO depth.
// *********************************************************************
`ifndef DIV_CONSTS_SVH
`define DIV_CONSTS_SVH

// operand and result width.
`define DIV_XLEN 64

// tag that follows a request to its result.
`define DIV_TAG_W 4

// default entries in each FIFO.
`define DIV_FIFO_DEPTH 4

`endif

/* src/div_op_pkg.sv */
// *********************************************************************
// Divide request types.
// Operation encoding, the raw input bundle and the decoded request.
// *********************************************************************
`default_nettype none

`include "div_consts.svh"

package div_op_pkg;

    // bit 2 word, bit 1 remainder, bit 0 unsigned.
    typedef enum logic [2:0] {
        OP_DIV   = 3'b000,
        OP_DIVU  = 3'b001,
        OP_REM   = 3'b010,
        OP_REMU  = 3'b011,
        OP_DIVW  = 3'b100,
        OP_DIVUW = 3'b101,
        OP_REMW  = 3'b110,
        OP_REMUW = 3'b111
    } div_op_e;

    // as presented on the input port.
    typedef struct packed {
        div_op_e                  op;
        logic [`DIV_TAG_W-1:0]    tag;
        logic [`DIV_XLEN-1:0]     dividend;
        logic [`DIV_XLEN-1:0]     divisor;
    } div_in_t;

    // decoded, as held in the request FIFO.
    typedef struct packed {
        logic [`DIV_TAG_W-1:0]    tag;
        logic                     is_signed;
        logic                     is_word;
        logic                     want_rem;
        logic [`DIV_XLEN-1:0]     dividend;
        logic [`DIV_XLEN-1:0]     divisor;
    } div_req_t;

endpackage

`default_nettype wire

/* src/div_res_pkg.sv */
// *********************************************************************
// Divide result types.
// *********************************************************************
`default_nettype none

`include "div_consts.svh"

package div_res_pkg;

    // value is the quotient or remainder, already sign-extended.
    typedef struct packed {
        logic [`DIV_TAG_W-1:0]    tag;
        logic [`DIV_XLEN-1:0]     value;
        logic                     div_by_zero;
    } div_res_t;

endpackage

`default_nettype wire

/* src/div_req_intake.sv */
// *********************************************************************
// Divide request intake.
// Four-phase receiver that decodes each request into the request FIFO.
// *********************************************************************
`timescale 1ns/1ns
`default_nettype none

module div_req_intake (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_req,
    input  div_op_pkg::div_in_t   in_data,
    output logic                  in_ack,
    output logic                  push,
    output div_op_pkg::div_req_t  push_data,
    input  logic                  full
);
    import div_op_pkg::*;

    typedef enum logic [1:0] {
        ST_WAIT_REQ,
        ST_ACK,
        ST_WAIT_FALL
    } state_e;

    state_e  state;
    div_op_e op;

    assign op = in_data.op;

    // accept only when there is room.
    assign push = (state == ST_WAIT_REQ) && in_req && !full;
    assign in_ack = (state != ST_WAIT_REQ);

    always_comb begin
        push_data.tag       = in_data.tag;
        push_data.is_signed = !op[0];
        push_data.is_word   = op[2];
        push_data.want_rem  = op[1];
        push_data.dividend  = in_data.dividend;
        push_data.divisor   = in_data.divisor;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_WAIT_REQ;
        end else begin
            case (state)
                ST_WAIT_REQ: if (push) state <= ST_ACK;
                ST_ACK:      state <= in_req ? ST_WAIT_FALL : ST_WAIT_REQ;
                ST_WAIT_FALL: if (!in_req) state <= ST_WAIT_REQ;
                default:     state <= ST_WAIT_REQ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/div_fifo.sv */
// *********************************************************************
// Show-ahead FIFO.
// Circular buffer with an occupancy count; the payload is a parameter.
// *********************************************************************
`timescale 1ns/1ns
`default_nettype none

`include "div_consts.svh"

module div_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = `DIV_FIFO_DEPTH
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_data,
    output logic     full,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST = PTR_W'(DEPTH - 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);
    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            // simultaneous push and pop leaves the count alone.
            if (do_push && !do_pop) count <= count + 1'b1;
            else if (do_pop && !do_push) count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

/* src/div_core.sv */
// *********************************************************************
// Iterative restoring divider.
// One quotient bit per cycle, RISC-V sign, word and special-case rules.
// *********************************************************************
`timescale 1ns/1ns
`default_nettype none

`include "div_consts.svh"

module div_core (
    input  logic                  clk,
    input  logic                  rst_n,
    input  div_op_pkg::div_req_t  req_head,
    input  logic                  req_empty,
    output logic                  req_pop,
    output logic                  res_push,
    output div_res_pkg::div_res_t res_data,
    input  logic                  res_full
);
    import div_op_pkg::*;
    import div_res_pkg::*;

    localparam int XLEN  = `DIV_XLEN;
    localparam int HALF  = XLEN / 2;
    localparam int CNT_W = $clog2(XLEN);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ITER,
        S_FINAL
    } state_e;

    state_e                 state;
    logic [CNT_W-1:0]       cnt;

    // operation context, captured at pop.
    logic [`DIV_TAG_W-1:0]  tag_q;
    logic                   word_q;
    logic                   rem_sel_q;
    logic                   neg_q_q;
    logic                   neg_r_q;
    logic                   dz_q;
    logic                   ovf_q;
    logic [XLEN-1:0]        dvd_q;
    logic [XLEN-1:0]        dvs_q;
    logic [XLEN-1:0]        rem_q;
    logic [XLEN-1:0]        quo_q;

    logic [XLEN-1:0]        a_ext;
    logic [XLEN-1:0]        b_ext;
    logic                   a_neg;
    logic                   b_neg;
    logic                   is_dz;
    logic                   is_ovf;
    logic [XLEN:0]          r_shift;
    logic [XLEN:0]          r_diff;
    logic [XLEN-1:0]        raw;

    // word forms see only the low half.
    function automatic logic [XLEN-1:0] ext_op(input logic [XLEN-1:0] v,
                                               input logic word,
                                               input logic sgn);
        if (!word) return v;
        return {{HALF{sgn & v[HALF-1]}}, v[HALF-1:0]};
    endfunction

    always_comb begin
        a_ext  = ext_op(req_head.dividend, req_head.is_word, req_head.is_signed);
        b_ext  = ext_op(req_head.divisor, req_head.is_word, req_head.is_signed);
        a_neg  = req_head.is_signed && a_ext[XLEN-1];
        b_neg  = req_head.is_signed && b_ext[XLEN-1];
        is_dz  = (b_ext == '0);
        is_ovf = req_head.is_signed && (b_ext == '1) &&
                 (a_ext == (req_head.is_word ? {{(HALF+1){1'b1}}, {(HALF-1){1'b0}}}
                                             : {1'b1, {(XLEN-1){1'b0}}}));
    end

    // shift in the next dividend bit and try the subtraction.
    assign r_shift = {rem_q, quo_q[XLEN-1]};
    assign r_diff  = r_shift - {1'b0, dvs_q};

    assign req_pop  = (state == S_IDLE) && !req_empty;
    assign res_push = (state == S_FINAL) && !res_full;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (req_pop) begin
                        state <= (is_dz || is_ovf) ? S_FINAL : S_ITER;
                        cnt   <= req_head.is_word ? CNT_W'(HALF - 1) : CNT_W'(XLEN - 1);
                    end
                end
                S_ITER: begin
                    if (cnt == '0) state <= S_FINAL;
                    cnt <= cnt - 1'b1;
                end
                S_FINAL: if (res_push) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_pop) begin
            tag_q     <= req_head.tag;
            word_q    <= req_head.is_word;
            rem_sel_q <= req_head.want_rem;
            neg_q_q   <= a_neg ^ b_neg;
            neg_r_q   <= a_neg;
            dz_q      <= is_dz;
            ovf_q     <= is_ovf;
            dvd_q     <= req_head.dividend;
            dvs_q     <= b_neg ? -b_ext : b_ext;
            rem_q     <= '0;
            // word magnitude goes to the top so the first shift sees bit 31.
            quo_q     <= req_head.is_word ? (a_neg ? -a_ext : a_ext) << HALF
                                          : (a_neg ? -a_ext : a_ext);
        end else if (state == S_ITER) begin
            rem_q <= r_diff[XLEN] ? r_shift[XLEN-1:0] : r_diff[XLEN-1:0];
            quo_q <= {quo_q[XLEN-2:0], !r_diff[XLEN]};
        end
    end

    always_comb begin
        if (dz_q) raw = rem_sel_q ? dvd_q : '1;
        else if (ovf_q) raw = rem_sel_q ? '0 : dvd_q;
        else if (rem_sel_q) raw = neg_r_q ? -rem_q : rem_q;
        else raw = neg_q_q ? -quo_q : quo_q;
        res_data.tag         = tag_q;
        res_data.value       = word_q ? {{HALF{raw[HALF-1]}}, raw[HALF-1:0]} : raw;
        res_data.div_by_zero = dz_q;
    end

endmodule

`default_nettype wire

/* src/div_result_port.sv */
// *********************************************************************
// Divide result port.
// Pops the result FIFO and runs a four-phase sender.
// *********************************************************************
`timescale 1ns/1ns
`default_nettype none

module div_result_port (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  empty,
    output logic                  pop,
    input  div_res_pkg::div_res_t pop_data,
    output logic                  out_req,
    output div_res_pkg::div_res_t out_data,
    input  logic                  out_ack
);
    import div_res_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_ACK_LOW
    } state_e;

    state_e   state;
    div_res_t data_q;

    assign pop      = (state == S_IDLE) && !empty;
    assign out_req  = (state == S_REQ);
    assign out_data = data_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:    if (pop) state <= S_REQ;
                S_REQ:     if (out_ack) state <= S_ACK_LOW;
                // next result only once the ack is gone.
                S_ACK_LOW: if (!out_ack) state <= S_IDLE;
                default:   state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) data_q <= pop_data;
    end

endmodule

`default_nettype wire

/* src/div_unit_top.sv */
// *********************************************************************
// Divide unit top level.
// Intake, request FIFO, divider core, result FIFO and result port.
// *********************************************************************
`timescale 1ns/1ns
`default_nettype none

`include "div_consts.svh"

module div_unit_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_req,
    input  div_op_pkg::div_in_t   in_data,
    output logic                  in_ack,
    output logic                  out_req,
    output div_res_pkg::div_res_t out_data,
    input  logic                  out_ack
);
    import div_op_pkg::*;
    import div_res_pkg::*;

    logic     rq_push;
    logic     rq_full;
    logic     rq_pop;
    logic     rq_empty;
    div_req_t rq_wdata;
    div_req_t rq_head;

    logic     rs_push;
    logic     rs_full;
    logic     rs_pop;
    logic     rs_empty;
    div_res_t rs_wdata;
    div_res_t rs_head;

    div_req_intake i_div_req_intake (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_req    (in_req),
        .in_data   (in_data),
        .in_ack    (in_ack),
        .push      (rq_push),
        .push_data (rq_wdata),
        .full      (rq_full)
    );

    div_fifo #(
        .payload_t (div_req_t),
        .DEPTH     (`DIV_FIFO_DEPTH)
    ) i_req_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (rq_push),
        .push_data (rq_wdata),
        .full      (rq_full),
        .pop       (rq_pop),
        .pop_data  (rq_head),
        .empty     (rq_empty)
    );

    div_core i_div_core (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_head  (rq_head),
        .req_empty (rq_empty),
        .req_pop   (rq_pop),
        .res_push  (rs_push),
        .res_data  (rs_wdata),
        .res_full  (rs_full)
    );

    div_fifo #(
        .payload_t (div_res_t),
        .DEPTH     (`DIV_FIFO_DEPTH)
    ) i_res_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (rs_push),
        .push_data (rs_wdata),
        .full      (rs_full),
        .pop       (rs_pop),
        .pop_data  (rs_head),
        .empty     (rs_empty)
    );

    div_result_port i_div_result_port (
        .clk      (clk),
        .rst_n    (rst_n),
        .empty    (rs_empty),
        .pop      (rs_pop),
        .pop_data (rs_head),
        .out_req  (out_req),
        .out_data (out_data),
        .out_ack  (out_ack)
    );

endmodule

`default_nettype wire

/* dv/div_unit_checker.sv */
// *********************************************************************
// Divide unit handshake checker.
// Assertions on the four-phase request and result ports.
// *********************************************************************
`timescale 1ns/1ns
`default_nettype none

module div_unit_checker (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  in_req,
    input logic                  in_ack,
    input logic                  out_req,
    input div_res_pkg::div_res_t out_data,
    input logic                  out_ack
);
    int err_cnt;

    // the ack follows a push, which needs the request high.
    in_ack_after_req: assert property (
        @(posedge clk) disable iff (!rst_n) $rose(in_ack) |-> $past(in_req)
    ) else begin
        err_cnt++;
        $error("in_ack rose while in_req was low");
    end

    out_held_until_ack: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_req && !out_ack |=> out_req && $stable(out_data)
    ) else begin
        err_cnt++;
        $error("out_req or out_data changed before out_ack");
    end

    // return to zero before the next result.
    out_low_during_ack: assert property (
        @(posedge clk) disable iff (!rst_n) out_ack && $past(out_ack) |-> !out_req
    ) else begin
        err_cnt++;
        $error("out_req high while out_ack still high");
    end

    out_low_after_reset: assert property (
        @(posedge clk) $rose(rst_n) |-> !out_req
    ) else begin
        err_cnt++;
        $error("out_req high right after reset");
    end

endmodule

`default_nettype wire

/* dv/div_unit_tb.sv */
// *********************************************************************
// Divide unit testbench.
// Four-phase driver and responder, reference model and in-order compare.
// *********************************************************************
`timescale 1ns/1ns
`default_nettype none

`include "div_consts.svh"

module div_unit_tb;
    import div_op_pkg::*;
    import div_res_pkg::*;

    localparam integer SEED    = 32'h6e925711;
    localparam int     TIMEOUT = 3000;
    localparam int     HOLD    = 800;
    localparam int     N_RAND  = 200;

    logic                  clk;
    logic                  rst_n;
    logic                  in_req;
    div_in_t               in_data;
    logic                  in_ack;
    logic                  out_req;
    div_res_t              out_data;
    logic                  out_ack;
    logic                  hold_ack = 1'b0;
    logic                  drv_done = 1'b0;
    integer                seed     = SEED;
    integer                ack_seed = SEED;
    logic [`DIV_TAG_W-1:0] next_tag = '0;
    int                    max_wait;
    div_in_t               sent_q[$];

    div_unit_top i_div_unit_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_req   (in_req),
        .in_data  (in_data),
        .in_ack   (in_ack),
        .out_req  (out_req),
        .out_data (out_data),
        .out_ack  (out_ack)
    );

    bind div_unit_top div_unit_checker i_div_unit_checker (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_req   (in_req),
        .in_ack   (in_ack),
        .out_req  (out_req),
        .out_data (out_data),
        .out_ack  (out_ack)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    function automatic logic [63:0] rand64();
        return {rand32(), rand32()};
    endfunction

    // RISC-V M-extension divide semantics.
    function automatic div_res_t div_ref(input div_in_t t);
        div_res_t    r;
        logic        word;
        logic        sgn;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] q;
        logic [63:0] m;
        logic [63:0] v;
        logic [63:0] min_v;
        word  = t.op[2];
        sgn   = !t.op[0];
        a     = t.dividend;
        b     = t.divisor;
        min_v = {1'b1, 63'h0};
        if (word) begin
            a     = {{32{sgn & a[31]}}, a[31:0]};
            b     = {{32{sgn & b[31]}}, b[31:0]};
            min_v = {{33{1'b1}}, 31'h0};
        end
        if (b == 64'h0) begin
            q = '1;
            m = a;
        end else if (sgn && a == min_v && b == '1) begin
            q = a;
            m = '0;
        end else if (sgn) begin
            q = $signed(a) / $signed(b);
            m = $signed(a) % $signed(b);
        end else begin
            q = a / b;
            m = a % b;
        end
        v             = t.op[1] ? m : q;
        r.tag         = t.tag;
        r.value       = word ? {{32{v[31]}}, v[31:0]} : v;
        r.div_by_zero = (b == 64'h0);
        return r;
    endfunction

    task automatic check_res(input div_res_t got, input div_res_t exp);
        if (got.tag !== exp.tag || got.value !== exp.value ||
            got.div_by_zero !== exp.div_by_zero) begin
            $display("error at %0t ns: got tag %0d %h dz %b, expected tag %0d %h dz %b",
                     $time, got.tag, got.value, got.div_by_zero,
                     exp.tag, exp.value, exp.div_by_zero);
            abort_run();
        end
    endtask

    task automatic send_req(input div_op_e op, input logic [63:0] a, input logic [63:0] b);
        div_in_t t;
        int      n;
        t.op       = op;
        t.tag      = next_tag;
        t.dividend = a;
        t.divisor  = b;
        next_tag   = next_tag + 1'b1;
        sent_q.push_back(t);
        in_data = t;
        in_req  = 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
            if (n > TIMEOUT) begin
                $display("timeout at %0t ns: in_ack never rose for tag %0d", $time, t.tag);
                abort_run();
            end
        end while (!in_ack);
        if (n > max_wait) max_wait = n;
        in_req = 1'b0;
        n = 0;
        while (in_ack) begin
            @(posedge clk);
            #1;
            n++;
            if (n > TIMEOUT) begin
                $display("timeout at %0t ns: in_ack stayed high after in_req fell", $time);
                abort_run();
            end
        end
    endtask

    task automatic send_random();
        logic [31:0] r;
        logic [63:0] b;
        r = rand32();
        b = rand64() >> r[5:0];
        // now and then a zero divisor.
        if (r[12:9] == 4'h0) b = '0;
        send_req(div_op_e'(r[2:0]), rand64(), b);
    endtask

    initial begin : driver
        in_req  = 1'b0;
        in_data = '0;
        rst_n   = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        // 64-bit forms over every sign combination.
        for (int s = 0; s < 4; s++) begin
            for (int k = 0; k < 4; k++) begin
                send_req(div_op_e'(k[2:0]), s[0] ? -64'd1000003 : 64'd1000003,
                         s[1] ? -64'd97 : 64'd97);
                send_req(div_op_e'(k[2:0]), rand64(), rand64() >> (8 * s));
            end
        end
        // word forms with garbage in the upper halves.
        for (int s = 0; s < 4; s++) begin
            for (int k = 4; k < 8; k++) begin
                send_req(div_op_e'(k[2:0]), {rand32(), s[0] ? -32'd1000003 : 32'd1000003},
                         {rand32(), s[1] ? -32'd97 : 32'd97});
            end
        end
        for (int k = 0; k < 8; k++) begin
            send_req(div_op_e'(k[2:0]), rand64(), 64'h0);
            if (k >= 4) send_req(div_op_e'(k[2:0]), rand64(), {rand32(), 32'h0});
        end
        send_req(OP_DIV, {1'b1, 63'h0}, '1);
        send_req(OP_REM, {1'b1, 63'h0}, '1);
        send_req(OP_DIVW, {rand32(), 32'h8000_0000}, {rand32(), 32'hffff_ffff});
        send_req(OP_REMW, {rand32(), 32'h8000_0000}, {rand32(), 32'hffff_ffff});
        // long out_ack hold so both FIFOs fill.
        @(negedge clk);
        hold_ack = 1'b1;
        max_wait = 0;
        fork
            begin
                repeat (HOLD) @(negedge clk);
                hold_ack = 1'b0;
            end
        join_none
        @(posedge clk);
        #1;
        repeat (14) send_random();
        // longer than any single divide, so the stall came from the output side.
        if (max_wait < 2 * `DIV_XLEN) begin
            $display("in_ack never stalled while out_ack was held off");
            abort_run();
        end
        repeat (N_RAND) send_random();
        drv_done = 1'b1;
    end

    initial begin : responder
        int delay;
        int linger;
        delay   = 0;
        linger  = 0;
        out_ack = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (out_ack && !out_req) begin
                // ack stays up a few cycles after out_req falls.
                if (linger == 0) begin
                    out_ack = 1'b0;
                    delay   = $unsigned($random(ack_seed)) % 6;
                end else begin
                    linger--;
                end
            end else if (out_req && !out_ack && !hold_ack) begin
                if (delay == 0) begin
                    out_ack = 1'b1;
                    linger  = $unsigned($random(ack_seed)) % 4;
                end else begin
                    delay--;
                end
            end
        end
    end

    initial begin : compare
        div_in_t  t;
        div_res_t got;
        int       n;
        int       n_checked;
        n_checked = 0;
        while (!drv_done || sent_q.size() != 0) begin
            n = 0;
            do begin
                @(posedge clk);
                #1;
                n++;
                if (n > TIMEOUT) begin
                    $display("timeout at %0t ns: no result appeared on out_req", $time);
                    abort_run();
                end
            end while (!out_req);
            got = out_data;
            if (sent_q.size() == 0) begin
                $display("error at %0t ns: result tag %0d has no request", $time, got.tag);
                abort_run();
            end
            t = sent_q.pop_front();
            check_res(got, div_ref(t));
            n_checked++;
            n = 0;
            while (out_req) begin
                @(posedge clk);
                #1;
                n++;
                if (n > TIMEOUT) begin
                    $display("timeout at %0t ns: out_req never fell after out_ack", $time);
                    abort_run();
                end
            end
        end
        if (i_div_unit_top.i_div_unit_checker.err_cnt == 0) begin
            $display("checked %0d results", n_checked);
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("handshake assertions failed %0d times",
                     i_div_unit_top.i_div_unit_checker.err_cnt);
            abort_run();
        end
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+src
src/div_op_pkg.sv
src/div_res_pkg.sv
src/div_req_intake.sv
src/div_fifo.sv
src/div_core.sv
src/div_result_port.sv
src/div_unit_top.sv
dv/div_unit_checker.sv
dv/div_unit_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the divide unit testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module div_unit_tb -f sources.f -o div_unit_sim

# assertion errors must not end the run before the testbench reports.
./obj_dir/div_unit_sim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\*\* PASSED \*\*\*' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
